// File: logic/rv32_params.svh
`ifndef RV32_PARAMS_SVH
`define RV32_PARAMS_SVH

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

// Data memory depth in 32-bit words
`define RV_DMEM_WORDS 64

// PC value held in the pipeline buffers out of reset
`define RV_RESET_PC 32'h0000_0000

`endif

// File: logic/rv32_pkg.sv
`default_nettype none

package rv32_pkg;

    typedef logic [31:0] rv32_word;

    typedef enum logic [2:0] {
        INSTR_R_TYPE,
        INSTR_I_TYPE,
        INSTR_S_TYPE,
        INSTR_B_TYPE,
        INSTR_U_TYPE,
        INSTR_J_TYPE
    } instr_type_t;

    typedef enum logic [1:0] {
        ALU_IN_REG_1,
        ALU_IN_REG_2,
        ALU_IN_PC,
        ALU_IN_IMM
    } int_alu_input_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS2
    } int_alu_op_t;

    typedef enum logic [2:0] {
        BRANCH_NONE,
        BRANCH_EQ,
        BRANCH_NE,
        BRANCH_LT,
        BRANCH_GE,
        BRANCH_LTU,
        BRANCH_GEU,
        BRANCH_ALWAYS
    } branch_op_t;

    typedef enum logic [1:0] {
        BYPASS_NONE,
        BYPASS_EXEC_BUFF,
        BYPASS_MEM_BUFF
    } bypass_t;

    typedef enum logic [2:0] {
        WB_NONE,
        WB_PC4,
        WB_INT_ALU,
        WB_STORE,
        WB_LOAD
    } wb_src_t;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_t;

    // 28 bits, first field in the MSBs
    typedef struct packed {
        instr_type_t    t;
        int_alu_input_t int_alu_i1;
        int_alu_input_t int_alu_i2;
        int_alu_op_t    int_alu_op;
        branch_op_t     branch_op;
        bypass_t        bypass_rs1;
        bypass_t        bypass_rs2;
        wb_src_t        wb_result_src;
        mem_op_t        mem_op;
        logic [4:0]     rd;
    } decoded_instr_t;

    typedef struct packed {
        rv32_word       instr;
        rv32_word       pc;
        rv32_word       reg1;
        rv32_word       reg2;
        decoded_instr_t decoded_instr;
    } decode_exec_buffer_t;

    typedef struct packed {
        rv32_word       instr;
        rv32_word       pc;
        decoded_instr_t decoded_instr;
        rv32_word       mem_addr;
        rv32_word       wb_result;
    } exec_mem_buffer_t;

    typedef struct packed {
        rv32_word       pc;
        decoded_instr_t decoded_instr;
        rv32_word       wb_result;
    } mem_wb_buffer_t;

    // addi x0,x0,0 with nothing written back
    function automatic decoded_instr_t create_nop_ctrl();
        decoded_instr_t ctrl;
        ctrl.t             = INSTR_I_TYPE;
        ctrl.int_alu_i1    = ALU_IN_REG_1;
        ctrl.int_alu_i2    = ALU_IN_IMM;
        ctrl.int_alu_op    = ALU_ADD;
        ctrl.branch_op     = BRANCH_NONE;
        ctrl.bypass_rs1    = BYPASS_NONE;
        ctrl.bypass_rs2    = BYPASS_NONE;
        ctrl.wb_result_src = WB_NONE;
        ctrl.mem_op        = MEM_NONE;
        ctrl.rd            = 5'd0;
        return ctrl;
    endfunction

endpackage

`default_nettype wire

// File: logic/rv32_imm_gen.sv
`timescale 1ns/1ns
`default_nettype none

module rv32_imm_gen (
    input  rv32_pkg::rv32_word    instr,
    input  rv32_pkg::instr_type_t fmt,
    output rv32_pkg::rv32_word    imm
);

    logic sign;

    // Every RV32I immediate takes its sign from bit 31
    assign sign = instr[31];

    always_comb begin
        case (fmt)
            rv32_pkg::INSTR_I_TYPE: begin
                imm = {{20{sign}}, instr[31:20]};
            end
            rv32_pkg::INSTR_S_TYPE: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            rv32_pkg::INSTR_B_TYPE: begin
                // Branch offsets are in halfwords
                imm = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            rv32_pkg::INSTR_U_TYPE: begin
                imm = {instr[31:12], 12'h000};
            end
            rv32_pkg::INSTR_J_TYPE: begin
                imm = {{11{sign}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                // R format has no immediate
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/rv32_int_alu.sv
`timescale 1ns/1ns
`default_nettype none

module rv32_int_alu (
    input  rv32_pkg::rv32_word    op1,
    input  rv32_pkg::rv32_word    op2,
    input  rv32_pkg::int_alu_op_t opsel,
    output rv32_pkg::rv32_word    result
);

    logic [4:0] shamt;

    assign shamt = op2[4:0];

    always_comb begin
        case (opsel)
            rv32_pkg::ALU_ADD: begin
                result = op1 + op2;
            end
            rv32_pkg::ALU_SUB: begin
                result = op1 - op2;
            end
            rv32_pkg::ALU_SLL: begin
                result = op1 << shamt;
            end
            rv32_pkg::ALU_SLT: begin
                result = {31'd0, $signed(op1) < $signed(op2)};
            end
            rv32_pkg::ALU_SLTU: begin
                result = {31'd0, op1 < op2};
            end
            rv32_pkg::ALU_XOR: begin
                result = op1 ^ op2;
            end
            rv32_pkg::ALU_SRL: begin
                result = op1 >> shamt;
            end
            rv32_pkg::ALU_SRA: begin
                result = rv32_pkg::rv32_word'($signed(op1) >>> shamt);
            end
            rv32_pkg::ALU_OR: begin
                result = op1 | op2;
            end
            rv32_pkg::ALU_AND: begin
                result = op1 & op2;
            end
            rv32_pkg::ALU_PASS2: begin
                // LUI, immediate straight through
                result = op2;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/rv32_branch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module rv32_branch_unit (
    input  rv32_pkg::rv32_word   op1,
    input  rv32_pkg::rv32_word   op2,
    input  rv32_pkg::branch_op_t branch_op,
    output logic                 do_branch
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (op1 == op2);
    assign lt_s = ($signed(op1) < $signed(op2));
    assign lt_u = (op1 < op2);

    always_comb begin
        case (branch_op)
            rv32_pkg::BRANCH_EQ:     do_branch = eq;
            rv32_pkg::BRANCH_NE:     do_branch = !eq;
            rv32_pkg::BRANCH_LT:     do_branch = lt_s;
            rv32_pkg::BRANCH_GE:     do_branch = !lt_s;
            rv32_pkg::BRANCH_LTU:    do_branch = lt_u;
            rv32_pkg::BRANCH_GEU:    do_branch = !lt_u;
            // JAL and JALR
            rv32_pkg::BRANCH_ALWAYS: do_branch = 1'b1;
            default:                 do_branch = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/rv32_exec_stage.sv
`timescale 1ns/1ns
`include "rv32_params.svh"
`default_nettype none

module rv32_exec_stage (
    input  logic                          clk,
    input  logic                          resetn,
    input  rv32_pkg::decode_exec_buffer_t decode_exec_buff,
    input  logic                          stop,
    input  rv32_pkg::mem_wb_buffer_t      mem_wb_buff,
    output rv32_pkg::exec_mem_buffer_t    exec_mem_buff,
    output logic                          do_jump,
    output rv32_pkg::rv32_word            jump_addr
);

    function automatic rv32_pkg::rv32_word pick_alu_input(
        input rv32_pkg::int_alu_input_t sel,
        input rv32_pkg::rv32_word       r1,
        input rv32_pkg::rv32_word       r2,
        input rv32_pkg::rv32_word       pc,
        input rv32_pkg::rv32_word       imm_val
    );
        rv32_pkg::rv32_word out;
        case (sel)
            rv32_pkg::ALU_IN_REG_1: out = r1;
            rv32_pkg::ALU_IN_REG_2: out = r2;
            rv32_pkg::ALU_IN_PC:    out = pc;
            rv32_pkg::ALU_IN_IMM:   out = imm_val;
        endcase
        return out;
    endfunction

    rv32_pkg::decoded_instr_t   ctrl;
    rv32_pkg::rv32_word         fwd_reg1;
    rv32_pkg::rv32_word         fwd_reg2;
    rv32_pkg::rv32_word         imm;
    rv32_pkg::rv32_word         alu_op1;
    rv32_pkg::rv32_word         alu_op2;
    rv32_pkg::rv32_word         alu_result;
    rv32_pkg::exec_mem_buffer_t next_buff;

    assign ctrl = decode_exec_buff.decoded_instr;

    // Bypass from our own output register or from the memory stage
    always_comb begin
        case (ctrl.bypass_rs1)
            rv32_pkg::BYPASS_EXEC_BUFF: fwd_reg1 = exec_mem_buff.wb_result;
            rv32_pkg::BYPASS_MEM_BUFF:  fwd_reg1 = mem_wb_buff.wb_result;
            default:                    fwd_reg1 = decode_exec_buff.reg1;
        endcase
        case (ctrl.bypass_rs2)
            rv32_pkg::BYPASS_EXEC_BUFF: fwd_reg2 = exec_mem_buff.wb_result;
            rv32_pkg::BYPASS_MEM_BUFF:  fwd_reg2 = mem_wb_buff.wb_result;
            default:                    fwd_reg2 = decode_exec_buff.reg2;
        endcase
    end

    rv32_imm_gen imm_gen (
        .instr (decode_exec_buff.instr),
        .fmt   (ctrl.t),
        .imm   (imm)
    );

    assign alu_op1 = pick_alu_input(ctrl.int_alu_i1, fwd_reg1, fwd_reg2,
                                    decode_exec_buff.pc, imm);
    assign alu_op2 = pick_alu_input(ctrl.int_alu_i2, fwd_reg1, fwd_reg2,
                                    decode_exec_buff.pc, imm);

    rv32_int_alu int_alu (
        .op1    (alu_op1),
        .op2    (alu_op2),
        .opsel  (ctrl.int_alu_op),
        .result (alu_result)
    );

    // Comparator sees the forwarded registers, not the ALU inputs
    rv32_branch_unit branch_unit (
        .op1       (fwd_reg1),
        .op2       (fwd_reg2),
        .branch_op (ctrl.branch_op),
        .do_branch (do_jump)
    );

    // Target is pc+imm or rs1+imm, both computed by the ALU
    assign jump_addr = alu_result;

    always_comb begin
        next_buff.instr         = decode_exec_buff.instr;
        next_buff.pc            = decode_exec_buff.pc;
        next_buff.decoded_instr = ctrl;
        next_buff.mem_addr      = alu_result;
        case (ctrl.wb_result_src)
            rv32_pkg::WB_PC4:     next_buff.wb_result = decode_exec_buff.pc + 32'd4;
            rv32_pkg::WB_INT_ALU: next_buff.wb_result = alu_result;
            // Store data rides along in wb_result
            rv32_pkg::WB_STORE:   next_buff.wb_result = fwd_reg2;
            default:              next_buff.wb_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            exec_mem_buff.instr         <= `RV_NOP;
            exec_mem_buff.pc            <= `RV_RESET_PC;
            exec_mem_buff.decoded_instr <= rv32_pkg::create_nop_ctrl();
        end else if (!stop) begin
            exec_mem_buff <= next_buff;
        end
    end

    // Memory stage must see a bubble on the first cycle out of reset
    nop_after_reset: assert property (@(posedge clk)
        $rose(resetn) |=> (exec_mem_buff.decoded_instr == rv32_pkg::create_nop_ctrl()
                           && exec_mem_buff.instr == `RV_NOP));

endmodule

`default_nettype wire

// File: logic/rv32_mem_stage.sv
`timescale 1ns/1ns
`include "rv32_params.svh"
`default_nettype none

module rv32_mem_stage (
    input  logic                       clk,
    input  logic                       resetn,
    input  rv32_pkg::exec_mem_buffer_t exec_mem_buff,
    input  logic                       stop,
    output rv32_pkg::mem_wb_buffer_t   mem_wb_buff
);

    localparam int ADDR_BITS = $clog2(`RV_DMEM_WORDS);

    rv32_pkg::rv32_word dmem [`RV_DMEM_WORDS];

    logic [ADDR_BITS-1:0] word_idx;
    logic                 is_load;
    logic                 store_en;
    rv32_pkg::rv32_word   load_data;

    // Byte address to word index, upper bits wrap
    assign word_idx  = exec_mem_buff.mem_addr[ADDR_BITS+1:2];
    assign is_load   = (exec_mem_buff.decoded_instr.mem_op == rv32_pkg::MEM_LOAD);
    assign store_en  = (exec_mem_buff.decoded_instr.mem_op == rv32_pkg::MEM_STORE) && !stop;
    assign load_data = dmem[word_idx];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (store_en) begin
            dmem[word_idx] <= exec_mem_buff.wb_result;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_wb_buff.pc            <= `RV_RESET_PC;
            mem_wb_buff.decoded_instr <= rv32_pkg::create_nop_ctrl();
            mem_wb_buff.wb_result     <= '0;
        end else if (!stop) begin
            mem_wb_buff.pc            <= exec_mem_buff.pc;
            mem_wb_buff.decoded_instr <= exec_mem_buff.decoded_instr;
            mem_wb_buff.wb_result     <= is_load ? load_data : exec_mem_buff.wb_result;
        end
    end

    // Execute computes the address, only word accesses are supported here
    word_aligned_access: assert property (@(posedge clk) disable iff (!resetn)
        (exec_mem_buff.decoded_instr.mem_op != rv32_pkg::MEM_NONE)
        |-> (exec_mem_buff.mem_addr[1:0] == 2'b00));

endmodule

`default_nettype wire

// File: logic/rv32_exec_subsys.sv
`timescale 1ns/1ns
`default_nettype none

module rv32_exec_subsys (
    input  logic                          clk,
    input  logic                          resetn,
    input  rv32_pkg::decode_exec_buffer_t decode_exec_buff,
    input  logic                          stop,
    output logic                          do_jump,
    output rv32_pkg::rv32_word            jump_addr,
    output rv32_pkg::exec_mem_buffer_t    exec_mem_buff,
    output rv32_pkg::mem_wb_buffer_t      mem_wb_buff
);

    rv32_exec_stage exec_stage (
        .clk              (clk),
        .resetn           (resetn),
        .decode_exec_buff (decode_exec_buff),
        .stop             (stop),
        .mem_wb_buff      (mem_wb_buff),
        .exec_mem_buff    (exec_mem_buff),
        .do_jump          (do_jump),
        .jump_addr        (jump_addr)
    );

    // mem_wb_buff also loops back as the second bypass source
    rv32_mem_stage mem_stage (
        .clk           (clk),
        .resetn        (resetn),
        .exec_mem_buff (exec_mem_buff),
        .stop          (stop),
        .mem_wb_buff   (mem_wb_buff)
    );

endmodule

`default_nettype wire

// File: tb/tb_exec_subsys.sv
`timescale 1ns/1ns
`include "rv32_params.svh"
`default_nettype none

module tb_exec_subsys;

    localparam int MAX_CASES      = 64;
    localparam int WORDS_PER_CASE = 10;
    localparam int CLK_PERIOD     = 8;

    logic                          clk;
    logic                          resetn;
    logic                          stop;
    rv32_pkg::decode_exec_buffer_t decode_exec_buff;
    logic                          do_jump;
    rv32_pkg::rv32_word            jump_addr;
    rv32_pkg::exec_mem_buffer_t    exec_mem_buff;
    rv32_pkg::mem_wb_buffer_t      mem_wb_buff;

    logic [31:0] case_words [0:MAX_CASES*WORDS_PER_CASE-1];
    int          num_cases = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          case_errors = 0;

    // Expected contents of the two buffers from the last two accepted cases
    logic [31:0] acc1_instr;
    logic [31:0] acc1_pc;
    logic [31:0] acc1_ctrl;
    logic [31:0] acc1_addr;
    logic [31:0] acc1_exec;
    logic [31:0] acc1_mem;
    logic [31:0] acc2_pc;
    logic [31:0] acc2_ctrl;
    logic [31:0] acc2_mem;
    int          num_accepted = 0;

    rv32_exec_subsys rv32_exec_subsys_inst (
        .clk              (clk),
        .resetn           (resetn),
        .decode_exec_buff (decode_exec_buff),
        .stop             (stop),
        .do_jump          (do_jump),
        .jump_addr        (jump_addr),
        .exec_mem_buff    (exec_mem_buff),
        .mem_wb_buff      (mem_wb_buff)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic compare_word(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
            case_errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (case_errors == 0) begin
            pass_count++;
            $display("PASS %s", name);
        end else begin
            fail_count++;
            $display("FAIL %0t ns: %s had %0d mismatches", $time, name, case_errors);
        end
        case_errors = 0;
    endtask

    task automatic check_reset_state();
        compare_word("exec_mem_buff.instr in reset", exec_mem_buff.instr, `RV_NOP);
        compare_word("do_jump in reset", {31'd0, do_jump}, 32'd0);
    endtask

    task automatic apply_case(input int base);
        rv32_pkg::decoded_instr_t ctrl;
        ctrl = case_words[base+4][27:0];
        decode_exec_buff.instr         = case_words[base];
        decode_exec_buff.pc            = case_words[base+1];
        decode_exec_buff.decoded_instr = ctrl;
        // Forwarded operands must ignore whatever decode supplies
        if (ctrl.bypass_rs1 != rv32_pkg::BYPASS_NONE) begin
            decode_exec_buff.reg1 = $urandom;
        end else begin
            decode_exec_buff.reg1 = case_words[base+2];
        end
        if (ctrl.bypass_rs2 != rv32_pkg::BYPASS_NONE) begin
            decode_exec_buff.reg2 = $urandom;
        end else begin
            decode_exec_buff.reg2 = case_words[base+3];
        end
        stop = case_words[base+5][0];
    endtask

    initial begin
        int idx;
        int base;
        void'($urandom(32'h705bac8e));
        resetn = 1'b0;
        stop   = 1'b0;
        decode_exec_buff.instr         = `RV_NOP;
        decode_exec_buff.pc            = `RV_RESET_PC;
        decode_exec_buff.reg1          = '0;
        decode_exec_buff.reg2          = '0;
        decode_exec_buff.decoded_instr = rv32_pkg::create_nop_ctrl();
        for (idx = 0; idx < MAX_CASES * WORDS_PER_CASE; idx++) begin
            case_words[idx] = 32'hffff_ffff;
        end
        $readmemh("tb/exec_cases.mem", case_words);
        while (num_cases < MAX_CASES && case_words[num_cases*WORDS_PER_CASE] != 32'hffff_ffff) begin
            num_cases++;
        end
        if (num_cases == 0) begin
            $display("No cases could be read from tb/exec_cases.mem");
            fail_count++;
        end

        repeat (4) begin
            @(negedge clk);
            check_reset_state();
        end
        resetn = 1'b1;
        @(negedge clk);
        check_reset_state();
        end_test("reset");

        for (idx = 0; idx < num_cases; idx++) begin
            base = idx * WORDS_PER_CASE;
            apply_case(base);
            #1;
            compare_word($sformatf("case %0d do_jump", idx), {31'd0, do_jump},
                         {31'd0, case_words[base+6][0]});
            compare_word($sformatf("case %0d jump_addr", idx), jump_addr, case_words[base+7]);
            @(negedge clk);
            if (case_words[base+5][0] == 1'b0) begin
                acc2_pc    = acc1_pc;
                acc2_ctrl  = acc1_ctrl;
                acc2_mem   = acc1_mem;
                acc1_instr = case_words[base];
                acc1_pc    = case_words[base+1];
                acc1_ctrl  = case_words[base+4];
                acc1_addr  = case_words[base+7];
                acc1_exec  = case_words[base+8];
                acc1_mem   = case_words[base+9];
                num_accepted++;
            end
            if (num_accepted >= 1) begin
                compare_word($sformatf("case %0d exec_mem_buff.instr", idx),
                             exec_mem_buff.instr, acc1_instr);
                compare_word($sformatf("case %0d exec_mem_buff.pc", idx),
                             exec_mem_buff.pc, acc1_pc);
                compare_word($sformatf("case %0d exec_mem_buff.decoded_instr", idx),
                             {4'd0, exec_mem_buff.decoded_instr}, acc1_ctrl);
                // Address is the ALU result, which also drives jump_addr
                compare_word($sformatf("case %0d exec_mem_buff.mem_addr", idx),
                             exec_mem_buff.mem_addr, acc1_addr);
                compare_word($sformatf("case %0d exec_mem_buff.wb_result", idx),
                             exec_mem_buff.wb_result, acc1_exec);
            end
            if (num_accepted >= 2) begin
                compare_word($sformatf("case %0d mem_wb_buff.pc", idx),
                             mem_wb_buff.pc, acc2_pc);
                compare_word($sformatf("case %0d mem_wb_buff.decoded_instr", idx),
                             {4'd0, mem_wb_buff.decoded_instr}, acc2_ctrl);
                compare_word($sformatf("case %0d mem_wb_buff.wb_result", idx),
                             mem_wb_buff.wb_result, acc2_mem);
            end
            end_test($sformatf("case %0d", idx));
        end

        $display("Tests finished: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog scaled to the number of cases
    initial begin
        wait (num_cases > 0);
        #((num_cases + 10) * 4 * CLK_PERIOD);
        $display("Simulation timed out before all cases finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/exec_cases.mem
// instr pc reg1 reg2 ctrl(28b) stop exp_jump exp_jump_addr exp_exec_wb exp_mem_wb
// Regs of a forwarded operand are replaced by random filler in the testbench
003100b3 00000100 00000005 00000007 0200101 0 0 0000000c 0000000c 0000000c
403100b3 00000104 00000003 00000010 0220101 0 0 fffffff3 fffffff3 fffffff3
fff10093 00000108 00000100 00000000 2600101 0 0 000000ff 000000ff 000000ff
40415093 0000010c 80000000 00000000 26e0101 0 0 f8000000 f8000000 f8000000
003120b3 00000110 ffffffff 00000001 0260101 0 0 00000001 00000001 00000001
003130b3 00000114 ffffffff 00000001 0280101 0 0 00000000 00000000 00000000
// lui, auipc
123450b7 00000118 00000000 00000000 8740101 0 0 12345000 12345000 12345000
00001097 0000011c 00000000 00000000 9600101 0 0 0000111c 0000111c 0000111c
// xor with rs1 from exec buffer, or with rs2 from mem buffer
0030c0b3 00000120 00000000 ffff0000 02a1101 0 0 ffff111c ffff111c ffff111c
003160b3 00000124 00f00000 00000000 0300901 0 0 00f0111c 00f0111c 00f0111c
// sw to 0x40, then lw from 0x40
fe312c23 00000128 00000048 cafef00d 46001c0 0 0 00000040 cafef00d cafef00d
04002083 0000012c 00000000 00000000 2600221 0 0 00000040 00000000 cafef00d
// beq taken, blt not taken, bltu taken, jal
00310863 00000130 00000055 00000055 7604000 0 1 00000140 00000000 00000000
fe314ce3 00000134 00000005 fffffffe 760c000 0 0 0000012c 00000000 00000000
fe316ce3 00000138 00000005 fffffffe 7614000 0 1 00000130 00000000 00000000
005000ef 0000013c 00000000 00000000 b61c081 0 1 00000940 00000140 00000140
// sw to 0x4 held by two stall cycles, then lw from 0x4
00312223 00000140 00000000 12345678 46001c0 0 0 00000004 12345678 12345678
00402083 00000144 00000000 00000000 2600221 1 0 00000004 00000000 00000000
00402083 00000144 00000000 00000000 2600221 1 0 00000004 00000000 00000000
00402083 00000144 00000000 00000000 2600221 0 0 00000004 00000000 12345678
003100b3 00000148 00000001 00000002 0200101 0 0 00000003 00000003 00000003
003080b3 0000014c 00000000 00000010 0202101 0 0 12345688 12345688 12345688
0030d0b3 00000150 00000000 00000024 02c1101 0 0 01234568 01234568 01234568
0f017093 00000154 0000abcd 00000000 2720101 0 0 000000c0 000000c0 000000c0
003110b3 00000158 00000001 0000001f 0240101 0 0 80000000 80000000 80000000
// jalr, bge taken, bne not taken
00c100e7 0000015c 00000200 00000000 261c081 0 1 0000020c 00000160 00000160
00315863 00000160 ffffffff ffffffff 7610000 0 1 00000170 00000000 00000000
00311863 00000164 00000007 00000007 7608000 0 0 00000174 00000000 00000000
// Bubbles to flush the pipeline
00000013 00000168 00000000 00000000 2600000 0 0 00000000 00000000 00000000
00000013 0000016c 00000000 00000000 2600000 0 0 00000000 00000000 00000000

// File: tb.f
+incdir+logic
logic/rv32_pkg.sv
logic/rv32_imm_gen.sv
logic/rv32_int_alu.sv
logic/rv32_branch_unit.sv
logic/rv32_exec_stage.sv
logic/rv32_mem_stage.sv
logic/rv32_exec_subsys.sv
tb/tb_exec_subsys.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation into sim.log and check it"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -j 0 -f tb.f --top-module tb_exec_subsys -Mdir obj_dir
	./obj_dir/Vtb_exec_subsys > sim.log 2>&1; cat sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
